//--- hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

   localparam int WORD_W  = 32;
   localparam int REG_W   = 5;
   localparam int OP_W    = 6;
   localparam int FUNCT_W = 6;
   localparam int SHAMT_W = 5;
   localparam int IMM_W   = 16;
   localparam int INDEX_W = 26;

   typedef logic [WORD_W-1:0]  word_t;
   typedef logic [REG_W-1:0]   reg_num_t;
   typedef logic [FUNCT_W-1:0] funct_t;

   // any opcode not listed here decodes as halt
   typedef enum logic [OP_W-1:0] {
      OP_SPECIAL = 6'h00,
      OP_J       = 6'h02,
      OP_JAL     = 6'h03,
      OP_BEQ     = 6'h04,
      OP_BNE     = 6'h05,
      OP_ADDI    = 6'h08,
      OP_SLTI    = 6'h0a,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LB      = 6'h20,
      OP_LH      = 6'h21,
      OP_LW      = 6'h23,
      OP_LBU     = 6'h24,
      OP_LHU     = 6'h25,
      OP_LWU     = 6'h27,
      OP_SB      = 6'h28,
      OP_SH      = 6'h29,
      OP_SW      = 6'h2b,
      OP_HALT    = 6'h3f
   } opcode_t;

   // special functs the decoder cares about
   localparam funct_t FUNCT_SLL  = 6'd0;
   localparam funct_t FUNCT_SRL  = 6'd2;
   localparam funct_t FUNCT_SRA  = 6'd3;
   localparam funct_t FUNCT_JR   = 6'd8;
   localparam funct_t FUNCT_JALR = 6'd9;

   typedef struct packed {
      opcode_t              opcode;
      reg_num_t             rs;
      reg_num_t             rt;
      reg_num_t             rd;
      logic [SHAMT_W-1:0]   shamt;
      funct_t               funct;
   } r_fmt_t;

   typedef struct packed {
      opcode_t              opcode;
      reg_num_t             rs;
      reg_num_t             rt;
      logic [IMM_W-1:0]     imm;
   } i_fmt_t;

   typedef struct packed {
      opcode_t              opcode;
      logic [INDEX_W-1:0]   index;
   } j_fmt_t;

   // one 32-bit word read three ways
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      j_fmt_t j;
   } instr_u;

endpackage

`default_nettype wire

//--- hw/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

   import isa_pkg::*;

   typedef enum logic [3:0] {
      ALU_NONE = 4'd0,
      ALU_ADD  = 4'd1,
      ALU_SLT  = 4'd2,
      ALU_AND  = 4'd3,
      ALU_OR   = 4'd4,
      ALU_XOR  = 4'd5,
      ALU_LUI  = 4'd6,
      ALU_JAL  = 4'd7,
      ALU_FUNC = 4'd8   // execute looks at funct
   } alu_op_t;

   typedef enum logic [1:0] {SRC_A_PC, SRC_A_RS, SRC_A_SHAMT, SRC_A_ZERO} src_a_t;
   typedef enum logic {SRC_B_RT, SRC_B_IMM} src_b_t;
   typedef enum logic [1:0] {DEST_RD, DEST_RT, DEST_R31} dest_t;
   typedef enum logic [1:0] {MEM_NONE, MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_t;
   typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_SIGN_BYTE, WB_SIGN_HALF} wb_src_t;

   // how the immediate is built from the instruction word
   typedef enum logic [1:0] {EXT_JUMP, EXT_SIGN, EXT_ZERO, EXT_SHAMT} ext_kind_t;

   typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} branch_kind_t;

   typedef struct packed {
      alu_op_t   alu_op;
      src_a_t    src_a;
      src_b_t    src_b;
      dest_t     dest;
   } exec_ctrl_t;

   typedef struct packed {
      mem_size_t rd_size;
      mem_size_t wr_size;
   } mem_ctrl_t;

   typedef struct packed {
      wb_src_t   wb_src;
      logic      reg_we;
   } wb_ctrl_t;

   // all zero is a no-op
   typedef struct packed {
      exec_ctrl_t exec;
      mem_ctrl_t  mem;
      wb_ctrl_t   wb;
   } ctrl_t;

   // write-back request into the register file
   typedef struct packed {
      logic      we;
      reg_num_t  addr;
      word_t     data;
   } reg_write_t;

   typedef struct packed {
      word_t     pc;
      word_t     rs_val;
      word_t     rt_val;
      word_t     imm;
      reg_num_t  rs_num;
      reg_num_t  rt_num;
      reg_num_t  rd_num;
      funct_t    funct;
      ctrl_t     ctrl;
   } id_ex_t;

endpackage

`default_nettype wire

//--- hw/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import isa_pkg::*, ctrl_pkg::*; (
   input  wire        i_clk,
   input  wire        i_rst,
   input  reg_num_t   i_rs_num,
   input  reg_num_t   i_rt_num,
   input  reg_write_t i_wb,
   output word_t      o_rs_val,
   output word_t      o_rt_val
);

   word_t regs [32];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int n = 0; n < 32; n++) begin
            regs[n] <= '0;
         end
      end else if (i_wb.we && i_wb.addr != '0) begin
         regs[i_wb.addr] <= i_wb.data;   // r0 never written
      end
   end

   // reads see a write landing on the same edge
   always_comb begin
      if (i_rs_num == '0)
         o_rs_val = '0;
      else if (i_wb.we && i_wb.addr == i_rs_num)
         o_rs_val = i_wb.data;
      else
         o_rs_val = regs[i_rs_num];

      if (i_rt_num == '0)
         o_rt_val = '0;
      else if (i_wb.we && i_wb.addr == i_rt_num)
         o_rt_val = i_wb.data;
      else
         o_rt_val = regs[i_rt_num];
   end

endmodule

`default_nettype wire

//--- hw/control_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module control_decoder import isa_pkg::*, ctrl_pkg::*; (
   input  instr_u       i_instr,
   output ctrl_t        o_ctrl,
   output word_t        o_imm,
   output branch_kind_t o_branch,
   output logic         o_jump,
   output logic         o_reg_jump,
   output logic         o_halt
);

   ext_kind_t ext_kind;

   always_comb begin
      // defaults give a no-op
      o_ctrl     = '0;
      o_branch   = BR_NONE;
      o_jump     = 1'b0;
      o_reg_jump = 1'b0;
      o_halt     = 1'b0;
      ext_kind   = EXT_ZERO;

      case (i_instr.r.opcode)
         OP_J: begin
            ext_kind = EXT_JUMP;
            o_jump   = 1'b1;
         end
         OP_JAL: begin
            ext_kind               = EXT_JUMP;
            o_jump                 = 1'b1;
            o_ctrl.exec.alu_op     = ALU_JAL;
            o_ctrl.exec.src_a      = SRC_A_PC;   // link address from pc
            o_ctrl.exec.dest       = DEST_R31;
            o_ctrl.wb.reg_we       = 1'b1;
         end
         OP_BEQ, OP_BNE: begin
            ext_kind = EXT_SIGN;
            o_branch = (i_instr.r.opcode == OP_BEQ) ? BR_EQ : BR_NE;
         end
         OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI: begin
            o_ctrl.exec.src_a = SRC_A_RS;
            o_ctrl.exec.src_b = SRC_B_IMM;
            o_ctrl.exec.dest  = DEST_RT;
            o_ctrl.wb.reg_we  = 1'b1;
            case (i_instr.r.opcode)
               OP_ADDI: o_ctrl.exec.alu_op = ALU_ADD;
               OP_SLTI: o_ctrl.exec.alu_op = ALU_SLT;
               OP_ANDI: o_ctrl.exec.alu_op = ALU_AND;
               OP_ORI:  o_ctrl.exec.alu_op = ALU_OR;
               default: o_ctrl.exec.alu_op = ALU_XOR;
            endcase
            // arithmetic sign-extends, logic zero-fills
            if (i_instr.r.opcode == OP_ADDI || i_instr.r.opcode == OP_SLTI)
               ext_kind = EXT_SIGN;
         end
         OP_LUI: begin
            o_ctrl.exec.alu_op = ALU_LUI;
            o_ctrl.exec.src_a  = SRC_A_ZERO;
            o_ctrl.exec.src_b  = SRC_B_IMM;
            o_ctrl.exec.dest   = DEST_RT;
            o_ctrl.wb.reg_we   = 1'b1;
         end
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU: begin
            ext_kind           = EXT_SIGN;   // base plus offset
            o_ctrl.exec.alu_op = ALU_ADD;
            o_ctrl.exec.src_a  = SRC_A_RS;
            o_ctrl.exec.src_b  = SRC_B_IMM;
            o_ctrl.exec.dest   = DEST_RT;
            o_ctrl.wb.reg_we   = 1'b1;
            o_ctrl.wb.wb_src   = WB_MEM;
            case (i_instr.r.opcode)
               OP_LB: begin
                  o_ctrl.mem.rd_size = MEM_BYTE;
                  o_ctrl.wb.wb_src   = WB_SIGN_BYTE;
               end
               OP_LH: begin
                  o_ctrl.mem.rd_size = MEM_HALF;
                  o_ctrl.wb.wb_src   = WB_SIGN_HALF;
               end
               OP_LBU:  o_ctrl.mem.rd_size = MEM_BYTE;
               OP_LHU:  o_ctrl.mem.rd_size = MEM_HALF;
               default: o_ctrl.mem.rd_size = MEM_WORD;   // lw, lwu
            endcase
         end
         OP_SB, OP_SH, OP_SW: begin
            ext_kind           = EXT_SIGN;
            o_ctrl.exec.alu_op = ALU_ADD;
            o_ctrl.exec.src_a  = SRC_A_RS;
            o_ctrl.exec.src_b  = SRC_B_IMM;
            o_ctrl.exec.dest   = DEST_RT;
            case (i_instr.r.opcode)
               OP_SB:   o_ctrl.mem.wr_size = MEM_BYTE;
               OP_SH:   o_ctrl.mem.wr_size = MEM_HALF;
               default: o_ctrl.mem.wr_size = MEM_WORD;
            endcase
         end
         OP_SPECIAL: begin
            ext_kind           = EXT_SHAMT;
            o_ctrl.exec.alu_op = ALU_FUNC;
            o_ctrl.exec.src_b  = SRC_B_RT;
            o_ctrl.exec.dest   = DEST_RD;
            o_ctrl.wb.reg_we   = 1'b1;
            case (i_instr.r.funct)
               FUNCT_SLL, FUNCT_SRL, FUNCT_SRA: o_ctrl.exec.src_a = SRC_A_SHAMT;
               FUNCT_JALR:                      o_ctrl.exec.src_a = SRC_A_PC;
               default:                         o_ctrl.exec.src_a = SRC_A_RS;
            endcase
            if (i_instr.r.funct == FUNCT_JR || i_instr.r.funct == FUNCT_JALR) begin
               o_jump     = 1'b1;
               o_reg_jump = 1'b1;
            end
            // jr links nothing, all-zero word is a nop
            if (i_instr.r.funct == FUNCT_JR || i_instr == '0)
               o_ctrl.wb.reg_we = 1'b0;
         end
         default: o_halt = 1'b1;   // halt and unused opcodes
      endcase

      case (ext_kind)
         EXT_JUMP:  o_imm = {{(WORD_W-INDEX_W){1'b0}}, i_instr.j.index};
         EXT_SIGN:  o_imm = {{(WORD_W-IMM_W){i_instr.i.imm[IMM_W-1]}}, i_instr.i.imm};
         EXT_ZERO:  o_imm = {{(WORD_W-IMM_W){1'b0}}, i_instr.i.imm};
         default:   o_imm = {{(WORD_W-SHAMT_W){1'b0}}, i_instr.r.shamt};
      endcase
   end

endmodule

`default_nettype wire

//--- hw/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit import isa_pkg::*, ctrl_pkg::*; (
   input  word_t        i_pc,
   input  word_t        i_rs_val,
   input  word_t        i_rt_val,
   input  word_t        i_imm,
   input  branch_kind_t i_branch,
   input  wire          i_jump,
   input  wire          i_reg_jump,
   output word_t        o_brh_addr,
   output word_t        o_jmp_addr,
   output logic         o_pc_beq,
   output logic         o_pc_src,
   output logic         o_flush,
   output logic         o_is_branch,
   output logic         o_is_reg_jump
);

   logic same;
   logic taken;

   assign same  = (i_rs_val == i_rt_val);
   assign taken = (i_branch == BR_EQ && same) || (i_branch == BR_NE && !same);

   // pc is already pc+4 here
   assign o_brh_addr = i_pc + {i_imm[WORD_W-3:0], 2'b00};

   // region jump keeps the top nibble of pc
   assign o_jmp_addr = i_reg_jump ? i_rs_val
                                  : {i_pc[WORD_W-1:WORD_W-4], i_imm[INDEX_W-1:0], 2'b00};

   assign o_pc_beq      = taken;
   assign o_pc_src      = i_jump;
   assign o_flush       = taken | i_jump;   // drop the fetched instruction
   assign o_is_branch   = (i_branch != BR_NONE);
   assign o_is_reg_jump = i_reg_jump;

endmodule

`default_nettype wire

//--- hw/id_ex_register.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_register import ctrl_pkg::*; (
   input  wire    i_clk,
   input  wire    i_rst,
   input  wire    i_bubble,
   input  id_ex_t i_next,
   output id_ex_t o_id_ex
);

   id_ex_t next_q;

   // a bubble keeps the data but kills every side effect
   always_comb begin
      next_q = i_next;
      if (i_bubble)
         next_q.ctrl = '0;
   end

   always_ff @(posedge i_clk) begin
      if (i_rst)
         o_id_ex <= '0;
      else
         o_id_ex <= next_q;
   end

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import isa_pkg::*, ctrl_pkg::*; (
   input  wire        i_clk,
   input  wire        i_rst,
   input  instr_u     i_instr,
   input  word_t      i_pc,        // already incremented
   input  reg_write_t i_wb,
   input  wire        i_bubble,
   output id_ex_t     o_id_ex,
   output word_t      o_brh_addr,
   output word_t      o_jmp_addr,
   output logic       o_pc_beq,
   output logic       o_pc_src,
   output logic       o_flush,
   output logic       o_is_branch,
   output logic       o_is_reg_jump,
   output logic       o_halt
);

   word_t        rs_val;
   word_t        rt_val;
   word_t        imm;
   ctrl_t        ctrl;
   branch_kind_t branch;
   logic         jump;
   logic         reg_jump;
   id_ex_t       id_ex_next;

   register_file u_register_file (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_rs_num (i_instr.r.rs),
      .i_rt_num (i_instr.r.rt),
      .i_wb     (i_wb),
      .o_rs_val (rs_val),
      .o_rt_val (rt_val)
   );

   control_decoder u_control_decoder (
      .i_instr    (i_instr),
      .o_ctrl     (ctrl),
      .o_imm      (imm),
      .o_branch   (branch),
      .o_jump     (jump),
      .o_reg_jump (reg_jump),
      .o_halt     (o_halt)
   );

   branch_unit u_branch_unit (
      .i_pc          (i_pc),
      .i_rs_val      (rs_val),
      .i_rt_val      (rt_val),
      .i_imm         (imm),
      .i_branch      (branch),
      .i_jump        (jump),
      .i_reg_jump    (reg_jump),
      .o_brh_addr    (o_brh_addr),
      .o_jmp_addr    (o_jmp_addr),
      .o_pc_beq      (o_pc_beq),
      .o_pc_src      (o_pc_src),
      .o_flush       (o_flush),
      .o_is_branch   (o_is_branch),
      .o_is_reg_jump (o_is_reg_jump)
   );

   // bundle for execute
   always_comb begin
      id_ex_next.pc     = i_pc;
      id_ex_next.rs_val = rs_val;
      id_ex_next.rt_val = rt_val;
      id_ex_next.imm    = imm;
      id_ex_next.rs_num = i_instr.r.rs;
      id_ex_next.rt_num = i_instr.r.rt;
      id_ex_next.rd_num = i_instr.r.rd;
      id_ex_next.funct  = i_instr.r.funct;
      id_ex_next.ctrl   = ctrl;
   end

   id_ex_register u_id_ex_register (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_bubble (i_bubble),
      .i_next   (id_ex_next),
      .o_id_ex  (o_id_ex)
   );

endmodule

`default_nettype wire

//--- testbench/tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage import isa_pkg::*, ctrl_pkg::*; ();

   localparam word_t PC_LOW  = 32'h0040_0100;
   localparam word_t PC_HIGH = 32'h9000_0010;   // top nibble shows in region jumps

   // flag order is taken, jump, reg_jump, branch, flush, halt
   localparam logic [5:0] FL_NONE     = 6'b000000;
   localparam logic [5:0] FL_BR       = 6'b000100;
   localparam logic [5:0] FL_BR_TAKEN = 6'b100110;
   localparam logic [5:0] FL_JUMP     = 6'b010010;
   localparam logic [5:0] FL_REG_JUMP = 6'b011010;
   localparam logic [5:0] FL_HALT     = 6'b000001;

   typedef struct packed {
      instr_u     instr;
      word_t      pc;
      logic       bubble;
      reg_write_t wb;
      ctrl_t      ctrl;
      word_t      imm;
      logic [5:0] flags;
      word_t      jmp;     // only looked at for jumps
   } entry_t;

   logic       clk;
   logic       rst;
   logic       bubble;
   instr_u     instr;
   word_t      pc;
   reg_write_t wb;
   id_ex_t     id_ex;
   word_t      brh_addr;
   word_t      jmp_addr;
   logic       pc_beq;
   logic       pc_src;
   logic       flush;
   logic       is_branch;
   logic       is_reg_jump;
   logic       halt;

   entry_t      table_q[$];
   string       names_q[$];
   word_t       model [32];   // predicted register contents
   word_t       vals [32];    // values the fill phase writes
   logic [31:0] lcg_state;
   int          errors;
   int          tests;
   int          failed_tests;

   decode_stage UUT (
      .i_clk         (clk),
      .i_rst         (rst),
      .i_instr       (instr),
      .i_pc          (pc),
      .i_wb          (wb),
      .i_bubble      (bubble),
      .o_id_ex       (id_ex),
      .o_brh_addr    (brh_addr),
      .o_jmp_addr    (jmp_addr),
      .o_pc_beq      (pc_beq),
      .o_pc_src      (pc_src),
      .o_flush       (flush),
      .o_is_branch   (is_branch),
      .o_is_reg_jump (is_reg_jump),
      .o_halt        (halt)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic instr_u make_r(reg_num_t rs, reg_num_t rt, reg_num_t rd,
                                     logic [4:0] shamt, funct_t funct);
      instr_u x;
      x.r.opcode = OP_SPECIAL;
      x.r.rs     = rs;
      x.r.rt     = rt;
      x.r.rd     = rd;
      x.r.shamt  = shamt;
      x.r.funct  = funct;
      return x;
   endfunction

   function automatic instr_u make_i(opcode_t op, reg_num_t rs, reg_num_t rt, logic [15:0] imm);
      instr_u x;
      x.i.opcode = op;
      x.i.rs     = rs;
      x.i.rt     = rt;
      x.i.imm    = imm;
      return x;
   endfunction

   function automatic instr_u make_j(opcode_t op, logic [25:0] index);
      instr_u x;
      x.j.opcode = op;
      x.j.index  = index;
      return x;
   endfunction

   function automatic ctrl_t mk_ctrl(alu_op_t alu, src_a_t a, src_b_t b, dest_t d,
                                     mem_size_t rd_sz, mem_size_t wr_sz, wb_src_t src,
                                     logic we);
      ctrl_t c;
      c.exec.alu_op = alu;
      c.exec.src_a  = a;
      c.exec.src_b  = b;
      c.exec.dest   = d;
      c.mem.rd_size = rd_sz;
      c.mem.wr_size = wr_sz;
      c.wb.wb_src   = src;
      c.wb.reg_we   = we;
      return c;
   endfunction

   function automatic ctrl_t imm_ctrl(alu_op_t alu);
      return mk_ctrl(alu, SRC_A_RS, SRC_B_IMM, DEST_RT, MEM_NONE, MEM_NONE, WB_ALU, 1'b1);
   endfunction

   function automatic ctrl_t load_ctrl(mem_size_t sz, wb_src_t src);
      return mk_ctrl(ALU_ADD, SRC_A_RS, SRC_B_IMM, DEST_RT, sz, MEM_NONE, src, 1'b1);
   endfunction

   function automatic ctrl_t store_ctrl(mem_size_t sz);
      return mk_ctrl(ALU_ADD, SRC_A_RS, SRC_B_IMM, DEST_RT, MEM_NONE, sz, WB_ALU, 1'b0);
   endfunction

   function automatic ctrl_t func_ctrl(src_a_t a, logic we);
      return mk_ctrl(ALU_FUNC, a, SRC_B_RT, DEST_RD, MEM_NONE, MEM_NONE, WB_ALU, we);
   endfunction

   // expected register read with the write-back bypass
   function automatic word_t read_model(reg_num_t n, reg_write_t w);
      if (n == '0)
         return '0;
      if (w.we && w.addr == n)
         return w.data;
      return model[n];
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests++;
      if (errors == errs_before) begin
         $display("test %0d %s passed", tests, name);
      end else begin
         failed_tests++;
         $display("test %0d %s failed with %0d errors", tests, name, errors - errs_before);
      end
   endtask

   task automatic add_entry(input string name, input instr_u in, input word_t p,
                            input ctrl_t c, input word_t imm, input logic [5:0] flags,
                            input word_t jmp, input logic bub, input reg_write_t w);
      entry_t e;
      e.instr  = in;
      e.pc     = p;
      e.bubble = bub;
      e.wb     = w;
      e.ctrl   = c;
      e.imm    = imm;
      e.flags  = flags;
      e.jmp    = jmp;
      table_q.push_back(e);
      names_q.push_back(name);
   endtask

   task automatic add_simple(input string name, input instr_u in, input word_t p,
                             input ctrl_t c, input word_t imm, input logic [5:0] flags,
                             input word_t jmp);
      add_entry(name, in, p, c, imm, flags, jmp, 1'b0, '0);
   endtask

   task automatic check_idle();
      check_val("o_id_ex.pc", '0, id_ex.pc);
      check_val("o_id_ex.rs_val", '0, id_ex.rs_val);
      check_val("o_id_ex.rt_val", '0, id_ex.rt_val);
      check_val("o_id_ex.imm", '0, id_ex.imm);
      check_val("o_id_ex.ctrl", '0, 32'(id_ex.ctrl));
      check_val("o_pc_beq", '0, 32'(pc_beq));
      check_val("o_pc_src", '0, 32'(pc_src));
      check_val("o_flush", '0, 32'(flush));
      check_val("o_halt", '0, 32'(halt));
   endtask

   task automatic build_table();
      word_t d;
      reg_write_t w;
      for (int r = 0; r < 32; r++) begin
         model[r] = '0;   // register file cleared by reset
         d = lcg_next();
         vals[r] = (r == 0) ? '0 : d;
         w.we   = 1'b1;
         w.addr = 5'(r);
         w.data = d;
         add_entry($sformatf("write r%0d", r), make_r(5'(r), 5'(r), 5'(r), 5'd0, 6'h20),
                   PC_LOW + 32'(r * 4), func_ctrl(SRC_A_RS, 1'b1), '0, FL_NONE, '0, 1'b0, w);
      end
      add_simple("nop", 32'h0, PC_LOW, func_ctrl(SRC_A_SHAMT, 1'b0), '0, FL_NONE, '0);
      add_simple("addi", make_i(OP_ADDI, 5'd4, 5'd3, 16'hfff0), PC_LOW, imm_ctrl(ALU_ADD),
                 32'hffff_fff0, FL_NONE, '0);
      add_simple("slti", make_i(OP_SLTI, 5'd6, 5'd5, 16'h0123), PC_LOW, imm_ctrl(ALU_SLT),
                 32'h0000_0123, FL_NONE, '0);
      add_simple("andi", make_i(OP_ANDI, 5'd8, 5'd7, 16'h8001), PC_LOW, imm_ctrl(ALU_AND),
                 32'h0000_8001, FL_NONE, '0);
      add_simple("ori", make_i(OP_ORI, 5'd1, 5'd2, 16'hf0f0), PC_LOW, imm_ctrl(ALU_OR),
                 32'h0000_f0f0, FL_NONE, '0);
      add_simple("xori", make_i(OP_XORI, 5'd3, 5'd4, 16'h5a5a), PC_LOW, imm_ctrl(ALU_XOR),
                 32'h0000_5a5a, FL_NONE, '0);
      add_simple("lui", make_i(OP_LUI, 5'd0, 5'd9, 16'habcd), PC_LOW,
                 mk_ctrl(ALU_LUI, SRC_A_ZERO, SRC_B_IMM, DEST_RT, MEM_NONE, MEM_NONE,
                         WB_ALU, 1'b1), 32'h0000_abcd, FL_NONE, '0);
      add_simple("lb", make_i(OP_LB, 5'd10, 5'd11, 16'hfffc), PC_LOW,
                 load_ctrl(MEM_BYTE, WB_SIGN_BYTE), 32'hffff_fffc, FL_NONE, '0);
      add_simple("lh", make_i(OP_LH, 5'd12, 5'd13, 16'h0010), PC_LOW,
                 load_ctrl(MEM_HALF, WB_SIGN_HALF), 32'h0000_0010, FL_NONE, '0);
      add_simple("lw", make_i(OP_LW, 5'd14, 5'd15, 16'h8000), PC_LOW,
                 load_ctrl(MEM_WORD, WB_MEM), 32'hffff_8000, FL_NONE, '0);
      add_simple("lbu", make_i(OP_LBU, 5'd16, 5'd17, 16'h0004), PC_LOW,
                 load_ctrl(MEM_BYTE, WB_MEM), 32'h0000_0004, FL_NONE, '0);
      add_simple("lhu", make_i(OP_LHU, 5'd18, 5'd19, 16'h7ffe), PC_LOW,
                 load_ctrl(MEM_HALF, WB_MEM), 32'h0000_7ffe, FL_NONE, '0);
      add_simple("lwu", make_i(OP_LWU, 5'd20, 5'd21, 16'h0020), PC_LOW,
                 load_ctrl(MEM_WORD, WB_MEM), 32'h0000_0020, FL_NONE, '0);
      add_simple("sb", make_i(OP_SB, 5'd22, 5'd23, 16'hfff8), PC_LOW, store_ctrl(MEM_BYTE),
                 32'hffff_fff8, FL_NONE, '0);
      add_simple("sh", make_i(OP_SH, 5'd24, 5'd25, 16'h0002), PC_LOW, store_ctrl(MEM_HALF),
                 32'h0000_0002, FL_NONE, '0);
      add_simple("sw", make_i(OP_SW, 5'd26, 5'd27, 16'h0100), PC_LOW, store_ctrl(MEM_WORD),
                 32'h0000_0100, FL_NONE, '0);
      add_simple("j", make_j(OP_J, 26'h012_3456), PC_HIGH, '0, 32'h0012_3456, FL_JUMP,
                 {PC_HIGH[31:28], 26'h012_3456, 2'b00});
      add_simple("jal", make_j(OP_JAL, 26'h3ff_ffff), PC_LOW,
                 mk_ctrl(ALU_JAL, SRC_A_PC, SRC_B_RT, DEST_R31, MEM_NONE, MEM_NONE,
                         WB_ALU, 1'b1), 32'h03ff_ffff, FL_JUMP,
                 {PC_LOW[31:28], 26'h3ff_ffff, 2'b00});
      // equal operands use the same register twice
      add_simple("beq equal", make_i(OP_BEQ, 5'd5, 5'd5, 16'hfffc), PC_LOW, '0,
                 32'hffff_fffc, FL_BR_TAKEN, '0);
      add_simple("beq unequal", make_i(OP_BEQ, 5'd5, 5'd6, 16'h0008), PC_LOW, '0,
                 32'h0000_0008, FL_BR, '0);
      add_simple("beq r0 r0", make_i(OP_BEQ, 5'd0, 5'd0, 16'h0001), PC_HIGH, '0,
                 32'h0000_0001, FL_BR_TAKEN, '0);
      add_simple("bne unequal", make_i(OP_BNE, 5'd5, 5'd6, 16'h0010), PC_LOW, '0,
                 32'h0000_0010, FL_BR_TAKEN, '0);
      add_simple("bne equal", make_i(OP_BNE, 5'd7, 5'd7, 16'h8000), PC_LOW, '0,
                 32'hffff_8000, FL_BR, '0);
      add_simple("sll", make_r(5'd0, 5'd2, 5'd10, 5'd7, FUNCT_SLL), PC_LOW,
                 func_ctrl(SRC_A_SHAMT, 1'b1), 32'd7, FL_NONE, '0);
      add_simple("srl", make_r(5'd0, 5'd3, 5'd11, 5'd31, FUNCT_SRL), PC_LOW,
                 func_ctrl(SRC_A_SHAMT, 1'b1), 32'd31, FL_NONE, '0);
      add_simple("sra", make_r(5'd0, 5'd4, 5'd12, 5'd16, FUNCT_SRA), PC_LOW,
                 func_ctrl(SRC_A_SHAMT, 1'b1), 32'd16, FL_NONE, '0);
      add_simple("sub", make_r(5'd13, 5'd14, 5'd15, 5'd0, 6'h22), PC_LOW,
                 func_ctrl(SRC_A_RS, 1'b1), '0, FL_NONE, '0);
      add_simple("jr", make_r(5'd11, 5'd0, 5'd0, 5'd0, FUNCT_JR), PC_HIGH,
                 func_ctrl(SRC_A_RS, 1'b0), '0, FL_REG_JUMP, vals[11]);
      add_simple("jalr", make_r(5'd12, 5'd0, 5'd31, 5'd0, FUNCT_JALR), PC_LOW,
                 func_ctrl(SRC_A_PC, 1'b1), '0, FL_REG_JUMP, vals[12]);
      add_entry("bubble lw", make_i(OP_LW, 5'd20, 5'd21, 16'h0040), PC_LOW,
                load_ctrl(MEM_WORD, WB_MEM), 32'h0000_0040, FL_NONE, '0, 1'b1, '0);
      add_simple("halt", 32'hfc00_0000, PC_LOW, '0, '0, FL_HALT, '0);
      add_simple("unused opcode", 32'he800_0000, PC_LOW, '0, '0, FL_HALT, '0);
   endtask

   task automatic run_entry(input int idx);
      entry_t e;
      word_t  exp_rs;
      word_t  exp_rt;
      ctrl_t  exp_ctrl;
      int     errs_before;
      e = table_q[idx];
      errs_before = errors;
      @(posedge clk);
      instr  <= e.instr;
      pc     <= e.pc;
      bubble <= e.bubble;
      wb     <= e.wb;
      @(negedge clk);
      exp_rs = read_model(e.instr.r.rs, e.wb);
      exp_rt = read_model(e.instr.r.rt, e.wb);
      check_val("o_pc_beq", 32'(e.flags[5]), 32'(pc_beq));
      check_val("o_pc_src", 32'(e.flags[4]), 32'(pc_src));
      check_val("o_is_reg_jump", 32'(e.flags[3]), 32'(is_reg_jump));
      check_val("o_is_branch", 32'(e.flags[2]), 32'(is_branch));
      check_val("o_flush", 32'(e.flags[1]), 32'(flush));
      check_val("o_halt", 32'(e.flags[0]), 32'(halt));
      check_val("o_brh_addr", e.pc + (e.imm << 2), brh_addr);
      if (e.flags[4])
         check_val("o_jmp_addr", e.jmp, jmp_addr);
      @(negedge clk);   // one edge later the bundle is registered
      exp_ctrl = e.bubble ? ctrl_t'('0) : e.ctrl;
      check_val("o_id_ex.pc", e.pc, id_ex.pc);
      check_val("o_id_ex.rs_val", exp_rs, id_ex.rs_val);
      check_val("o_id_ex.rt_val", exp_rt, id_ex.rt_val);
      check_val("o_id_ex.imm", e.imm, id_ex.imm);
      check_val("o_id_ex.rs_num", 32'(e.instr.r.rs), 32'(id_ex.rs_num));
      check_val("o_id_ex.rt_num", 32'(e.instr.r.rt), 32'(id_ex.rt_num));
      check_val("o_id_ex.rd_num", 32'(e.instr.r.rd), 32'(id_ex.rd_num));
      check_val("o_id_ex.funct", 32'(e.instr.r.funct), 32'(id_ex.funct));
      check_val("o_id_ex.ctrl", 32'(exp_ctrl), 32'(id_ex.ctrl));
      if (e.wb.we && e.wb.addr != '0)
         model[e.wb.addr] = e.wb.data;
      report_test(names_q[idx], errs_before);
   endtask

   initial begin
      int   wait_cycles;
      int   errs_before;
      logic reset_ok;
      lcg_state    = 32'h03d6_98d1;
      errors       = 0;
      tests        = 0;
      failed_tests = 0;
      rst    = 1'b1;
      instr  = '0;
      pc     = '0;
      wb     = '0;
      bubble = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      errs_before = errors;
      check_idle();   // inside reset
      @(posedge clk);
      rst <= 1'b0;
      wait_cycles = 0;
      while (rst && wait_cycles < 10) begin
         @(negedge clk);
         wait_cycles++;
      end
      reset_ok = !rst;
      if (!reset_ok) begin
         $display("reset still high after %0d cycles, giving up", wait_cycles);
      end else begin
         check_idle();   // first cycle out of reset
         report_test("reset", errs_before);
         build_table();
         for (int i = 0; i < table_q.size(); i++) begin
            run_entry(i);
         end
      end
      $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
      if (reset_ok && errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/register_file.sv
hw/control_decoder.sv
hw/branch_unit.sv
hw/id_ex_register.sv
hw/decode_stage.sv
testbench/tb_decode_stage.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_decode_stage
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides pass or fail
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
